// ==== design/gat_pkg.sv ====
package gat_pkg;

  // data widths
  localparam int DATA_WIDTH     = 16;
  localparam int HALF_A_SIZE    = 8;
  localparam int A_DEPTH        = 16;
  localparam int PROD_WIDTH     = 32;
  localparam int NUM_NODE_WIDTH = 7;

  // features on top, then the count field and the flag at bit 0
  localparam int WH_WIDTH       = 136;

  // adder tree depth for eight products
  localparam int TREE_LEVELS    = 3;

  // buffer depths and credits
  localparam int IN_CREDITS      = 4;
  localparam int COEF_FIFO_DEPTH = 8;
  localparam int OUT_CREDITS     = 4;

  typedef logic [DATA_WIDTH-1:0]                 data_t;
  typedef logic [PROD_WIDTH-1:0]                 prod_t;
  typedef logic [WH_WIDTH-1:0]                   wh_word_t;
  typedef logic [NUM_NODE_WIDTH-1:0]             cnt_t;

  // element 0 in the low bits and the source half in 0 to 7
  typedef logic [A_DEPTH*DATA_WIDTH-1:0]         a_vec_t;

  // element 0 in the top bits as in the word
  typedef logic [HALF_A_SIZE*DATA_WIDTH-1:0]     feat_vec_t;

  // product k in bits k*PROD_WIDTH and up
  typedef logic [HALF_A_SIZE*PROD_WIDTH-1:0]     prod_vec_t;

endpackage

// ==== design/wh_admit.sv ====
`timescale 1ns/1ps

module wh_admit (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wh_valid_i,
  input  gat_pkg::wh_word_t wh_data_i,
  input  logic              slot_free_i,
  output logic              wh_credit_o,
  output logic              issue_valid_o,
  output gat_pkg::wh_word_t issue_word_o,
  output logic              issue_last_o
);

  gat_pkg::wh_word_t                             buf_mem [gat_pkg::IN_CREDITS];
  logic [$clog2(gat_pkg::IN_CREDITS)-1:0]        wr_ptr;
  logic [$clog2(gat_pkg::IN_CREDITS)-1:0]        rd_ptr;
  logic [$clog2(gat_pkg::IN_CREDITS+1)-1:0]      fill;
  logic [$clog2(gat_pkg::COEF_FIFO_DEPTH+1)-1:0] resv_cnt;
  gat_pkg::cnt_t                                 nb_left;
  gat_pkg::wh_word_t                             head;
  logic                                          head_src;
  logic                                          issue;
  logic                                          nb_issue;

  assign head     = buf_mem[rd_ptr];
  assign head_src = head[0];

  // a neighbor needs a coefficient slot booked downstream
  assign issue    = (fill != '0) && (head_src || (resv_cnt < gat_pkg::COEF_FIFO_DEPTH));
  assign nb_issue = issue && !head_src;

  // storage for incoming words
  always_ff @(posedge clk) begin
    if (wh_valid_i) begin
      buf_mem[wr_ptr] <= wh_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill          <= '0;
      resv_cnt      <= '0;
      nb_left       <= '0;
      wh_credit_o   <= 1'b0;
      issue_valid_o <= 1'b0;
      issue_last_o  <= 1'b0;
    end else begin
      if (wh_valid_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (issue) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wh_valid_i, issue})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // booked on neighbor issue and released on every pop
      case ({nb_issue, slot_free_i})
        2'b10:   resv_cnt <= resv_cnt + 1'b1;
        2'b01:   resv_cnt <= resv_cnt - 1'b1;
        default: resv_cnt <= resv_cnt;
      endcase
      // group member count from the source word
      if (issue && head_src) begin
        nb_left <= head[gat_pkg::NUM_NODE_WIDTH:1];
      end else if (nb_issue) begin
        nb_left <= nb_left - 1'b1;
      end
      wh_credit_o   <= issue;
      issue_valid_o <= issue;
      issue_last_o  <= nb_issue && (nb_left == 1);
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      issue_word_o <= head;
    end
  end

endmodule

// ==== design/dmvm_mult.sv ====
`timescale 1ns/1ps

module dmvm_mult (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               a_valid_i,
  input  gat_pkg::a_vec_t    a_i,
  input  logic               issue_valid_i,
  input  gat_pkg::wh_word_t  issue_word_i,
  input  logic               issue_last_i,
  output logic               prod_valid_o,
  output gat_pkg::prod_vec_t prod_vec_o,
  output logic               prod_src_o,
  output logic               prod_last_o
);

  gat_pkg::a_vec_t    a_q;
  gat_pkg::feat_vec_t feats;
  gat_pkg::prod_vec_t prod_d;
  logic               src_flag;

  assign feats    = issue_word_i[gat_pkg::WH_WIDTH-1 -: gat_pkg::HALF_A_SIZE*gat_pkg::DATA_WIDTH];
  assign src_flag = issue_word_i[0];

  always_ff @(posedge clk) begin
    if (a_valid_i) begin
      a_q <= a_i;
    end
  end

  // flag picks source half (0..7) or neighbor half (8..15)
  for (genvar k = 0; k < gat_pkg::HALF_A_SIZE; k++) begin : g_mul
    gat_pkg::data_t feat;
    gat_pkg::data_t wgt;

    assign feat = feats[(gat_pkg::HALF_A_SIZE-1-k)*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH];
    assign wgt  = src_flag ? a_q[k*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH]
                           : a_q[(k+gat_pkg::HALF_A_SIZE)*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH];
    assign prod_d[k*gat_pkg::PROD_WIDTH +: gat_pkg::PROD_WIDTH] = $signed(feat) * $signed(wgt);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_valid_o <= 1'b0;
      prod_src_o   <= 1'b0;
      prod_last_o  <= 1'b0;
    end else begin
      prod_valid_o <= issue_valid_i;
      prod_src_o   <= issue_valid_i && src_flag;
      prod_last_o  <= issue_valid_i && issue_last_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid_i) begin
      prod_vec_o <= prod_d;
    end
  end

endmodule

// ==== design/dmvm_reduce.sv ====
`timescale 1ns/1ps

module dmvm_reduce (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               prod_valid_i,
  input  gat_pkg::prod_vec_t prod_vec_i,
  input  logic               prod_src_i,
  input  logic               prod_last_i,
  output logic               coef_wr_o,
  output gat_pkg::data_t     coef_wdata_o,
  output logic               coef_wlast_o
);

  gat_pkg::prod_t                   l1_q [gat_pkg::HALF_A_SIZE/2];
  gat_pkg::prod_t                   l2_q [gat_pkg::HALF_A_SIZE/4];
  gat_pkg::prod_t                   l3_q;
  logic [gat_pkg::TREE_LEVELS-1:0]  vld_q;
  logic [gat_pkg::TREE_LEVELS-1:0]  src_q;
  logic [gat_pkg::TREE_LEVELS-1:0]  last_q;
  gat_pkg::prod_t                   src_sum_q;
  gat_pkg::prod_t                   total;
  gat_pkg::prod_t                   shifted;
  gat_pkg::data_t                   coef_raw;
  logic                             tree_vld;
  logic                             tree_src;
  logic                             tree_last;

  // adder tree 8 -> 4 -> 2 -> 1 with one register per level
  always_ff @(posedge clk) begin
    for (int i = 0; i < gat_pkg::HALF_A_SIZE/2; i++) begin
      l1_q[i] <= $signed(prod_vec_i[(2*i)*gat_pkg::PROD_WIDTH +: gat_pkg::PROD_WIDTH])
               + $signed(prod_vec_i[(2*i+1)*gat_pkg::PROD_WIDTH +: gat_pkg::PROD_WIDTH]);
    end
    for (int i = 0; i < gat_pkg::HALF_A_SIZE/4; i++) begin
      l2_q[i] <= $signed(l1_q[2*i]) + $signed(l1_q[2*i+1]);
    end
    l3_q <= $signed(l2_q[0]) + $signed(l2_q[1]);
  end

  // sideband travels with the sums
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= '0;
      src_q  <= '0;
      last_q <= '0;
    end else begin
      vld_q  <= {vld_q[gat_pkg::TREE_LEVELS-2:0], prod_valid_i};
      src_q  <= {src_q[gat_pkg::TREE_LEVELS-2:0], prod_src_i};
      last_q <= {last_q[gat_pkg::TREE_LEVELS-2:0], prod_last_i};
    end
  end

  assign tree_vld  = vld_q[gat_pkg::TREE_LEVELS-1];
  assign tree_src  = src_q[gat_pkg::TREE_LEVELS-1];
  assign tree_last = last_q[gat_pkg::TREE_LEVELS-1];

  // neighbor sum plus held source sum shifted back to data width
  assign total    = $signed(l3_q) + $signed(src_sum_q);
  assign shifted  = $signed(total) >>> (gat_pkg::PROD_WIDTH - gat_pkg::DATA_WIDTH);
  assign coef_raw = shifted[gat_pkg::DATA_WIDTH-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_wr_o    <= 1'b0;
      coef_wlast_o <= 1'b0;
    end else begin
      coef_wr_o    <= tree_vld && !tree_src;
      coef_wlast_o <= tree_vld && !tree_src && tree_last;
    end
  end

  always_ff @(posedge clk) begin
    if (tree_vld && tree_src) begin
      src_sum_q <= l3_q;
    end
    // negative coefficients clamp to zero
    if (tree_vld && !tree_src) begin
      coef_wdata_o <= coef_raw[gat_pkg::DATA_WIDTH-1] ? '0 : coef_raw;
    end
  end

endmodule

// ==== design/coef_fifo.sv ====
`timescale 1ns/1ps

module coef_fifo (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           coef_wr_i,
  input  gat_pkg::data_t coef_wdata_i,
  input  logic           coef_wlast_i,
  input  logic           coef_credit_i,
  output logic           coef_valid_o,
  output gat_pkg::data_t coef_o,
  output logic           coef_last_o,
  output logic           slot_free_o
);

  // entry is {last, coef}
  logic [gat_pkg::DATA_WIDTH:0]                  mem [gat_pkg::COEF_FIFO_DEPTH];
  logic [$clog2(gat_pkg::COEF_FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(gat_pkg::COEF_FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(gat_pkg::COEF_FIFO_DEPTH+1)-1:0] fill;
  logic [$clog2(gat_pkg::OUT_CREDITS+1)-1:0]     credit_cnt;
  logic [gat_pkg::DATA_WIDTH:0]                  head;
  logic                                          empty;
  logic                                          pop;
  logic                                          push;
  logic                                          mem_pop;

  assign empty   = (fill == '0);
  // empty buffer passes the incoming write straight through
  assign head    = empty ? {coef_wlast_i, coef_wdata_i} : mem[rd_ptr];
  assign pop     = (!empty || coef_wr_i) && (credit_cnt != '0);
  assign mem_pop = pop && !empty;
  assign push    = coef_wr_i && !(empty && pop);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {coef_wlast_i, coef_wdata_i};
    end
    if (pop) begin
      {coef_last_o, coef_o} <= head;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      fill         <= '0;
      credit_cnt   <= ($clog2(gat_pkg::OUT_CREDITS+1))'(gat_pkg::OUT_CREDITS);
      coef_valid_o <= 1'b0;
      slot_free_o  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, mem_pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // returned credit and pop in one cycle cancel
      case ({pop, coef_credit_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      coef_valid_o <= pop;
      slot_free_o  <= pop;
    end
  end

endmodule

// ==== design/gat_coef_top.sv ====
`timescale 1ns/1ps

module gat_coef_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              a_valid_i,
  input  gat_pkg::a_vec_t   a_i,
  input  logic              wh_valid_i,
  input  gat_pkg::wh_word_t wh_data_i,
  output logic              wh_credit_o,
  output logic              coef_valid_o,
  output gat_pkg::data_t    coef_o,
  output logic              coef_last_o,
  input  logic              coef_credit_i
);

  logic               issue_valid;
  gat_pkg::wh_word_t  issue_word;
  logic               issue_last;
  logic               prod_valid;
  gat_pkg::prod_vec_t prod_vec;
  logic               prod_src;
  logic               prod_last;
  logic               coef_wr;
  gat_pkg::data_t     coef_wdata;
  logic               coef_wlast;
  logic               slot_free;

  wh_admit u_admit (
    .clk           (clk),
    .rst_n         (rst_n),
    .wh_valid_i    (wh_valid_i),
    .wh_data_i     (wh_data_i),
    .slot_free_i   (slot_free),
    .wh_credit_o   (wh_credit_o),
    .issue_valid_o (issue_valid),
    .issue_word_o  (issue_word),
    .issue_last_o  (issue_last)
  );

  dmvm_mult u_mult (
    .clk           (clk),
    .rst_n         (rst_n),
    .a_valid_i     (a_valid_i),
    .a_i           (a_i),
    .issue_valid_i (issue_valid),
    .issue_word_i  (issue_word),
    .issue_last_i  (issue_last),
    .prod_valid_o  (prod_valid),
    .prod_vec_o    (prod_vec),
    .prod_src_o    (prod_src),
    .prod_last_o   (prod_last)
  );

  dmvm_reduce u_reduce (
    .clk          (clk),
    .rst_n        (rst_n),
    .prod_valid_i (prod_valid),
    .prod_vec_i   (prod_vec),
    .prod_src_i   (prod_src),
    .prod_last_i  (prod_last),
    .coef_wr_o    (coef_wr),
    .coef_wdata_o (coef_wdata),
    .coef_wlast_o (coef_wlast)
  );

  // slot_free closes the reservation loop back to admission
  coef_fifo u_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .coef_wr_i     (coef_wr),
    .coef_wdata_i  (coef_wdata),
    .coef_wlast_i  (coef_wlast),
    .coef_credit_i (coef_credit_i),
    .coef_valid_o  (coef_valid_o),
    .coef_o        (coef_o),
    .coef_last_o   (coef_last_o),
    .slot_free_o   (slot_free)
  );

endmodule

// ==== sim/tb_gat_coef.sv ====
`timescale 1ns/1ps

module tb_gat_coef;

  // about 300 words and 20 stalls of 200 cycles with margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int MAX_STALLS     = 20;

  logic               clk;
  logic               rst_n;
  logic               a_valid;
  gat_pkg::a_vec_t    a_vec;
  logic               wh_valid;
  gat_pkg::wh_word_t  wh_data;
  logic               wh_credit;
  logic               coef_valid;
  gat_pkg::data_t     coef;
  logic               coef_last;
  logic               coef_credit;

  gat_pkg::wh_word_t  wh_q [$];
  gat_pkg::data_t     exp_coef_q [$];
  logic               exp_last_q [$];
  gat_pkg::a_vec_t    a_cur;
  int                 in_credits;
  int                 credits_seen;
  int                 words_sent;
  int                 gap_left;
  int                 gap_max;
  int                 held;
  int                 stall_left;
  int                 stall_phases;
  int                 cycle_cnt;
  bit                 stall_enable;
  bit                 first_sent;

  gat_coef_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .a_valid_i     (a_valid),
    .a_i           (a_vec),
    .wh_valid_i    (wh_valid),
    .wh_data_i     (wh_data),
    .wh_credit_o   (wh_credit),
    .coef_valid_o  (coef_valid),
    .coef_o        (coef),
    .coef_last_o   (coef_last),
    .coef_credit_i (coef_credit)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_coef(input gat_pkg::data_t exp, input gat_pkg::data_t act);
    if (exp !== act) begin
      report_failure($sformatf("[ERROR] %0t ns coef_o expected %0d actual %0d",
                               $time, exp, act));
    end
  endtask

  task automatic check_last(input logic exp, input logic act);
    if (exp !== act) begin
      report_failure($sformatf("[ERROR] %0t ns coef_last_o expected %b actual %b",
                               $time, exp, act));
    end
  endtask

  task automatic check_idle(input string name, input logic act);
    if (act !== 1'b0) begin
      report_failure($sformatf("[ERROR] %0t ns %s expected 0 actual %b", $time, name, act));
    end
  endtask

  // signed value in -1024 .. 1023
  function automatic gat_pkg::data_t random_value();
    int v;
    v = int'($urandom_range(2047)) - 1024;
    return gat_pkg::data_t'(v);
  endfunction

  // element 0 sits in the top bits
  function automatic gat_pkg::feat_vec_t random_feats();
    gat_pkg::feat_vec_t f;
    for (int k = 0; k < gat_pkg::HALF_A_SIZE; k++) begin
      f[(gat_pkg::HALF_A_SIZE-1-k)*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH] = random_value();
    end
    return f;
  endfunction

  // source dot plus neighbor dot shifted back to data width with negatives clamped
  function automatic gat_pkg::data_t expected_coef(input gat_pkg::a_vec_t a,
                                                   input gat_pkg::feat_vec_t src_feat,
                                                   input gat_pkg::feat_vec_t nb_feat);
    longint         total;
    longint         shifted;
    gat_pkg::data_t res;
    total = 0;
    for (int k = 0; k < gat_pkg::HALF_A_SIZE; k++) begin
      total += longint'($signed(src_feat[(7-k)*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH]))
             * longint'($signed(a[k*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH]));
      total += longint'($signed(nb_feat[(7-k)*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH]))
             * longint'($signed(a[(k+8)*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH]));
    end
    shifted = total >>> 16;
    res = gat_pkg::data_t'(shifted);
    if (res[gat_pkg::DATA_WIDTH-1]) begin
      res = '0;
    end
    return res;
  endfunction

  // queue one source word and its neighbors along with expected results
  task automatic add_group(input int n_nb);
    gat_pkg::feat_vec_t src_feat;
    gat_pkg::feat_vec_t nb_feat;
    gat_pkg::cnt_t      cnt;
    src_feat = random_feats();
    cnt = gat_pkg::cnt_t'(n_nb);
    wh_q.push_back({src_feat, cnt, 1'b1});
    for (int i = 0; i < n_nb; i++) begin
      nb_feat = random_feats();
      wh_q.push_back({nb_feat, gat_pkg::cnt_t'(0), 1'b0});
      exp_coef_q.push_back(expected_coef(a_cur, src_feat, nb_feat));
      exp_last_q.push_back(i == n_nb - 1);
    end
  endtask

  task automatic load_weights();
    for (int k = 0; k < gat_pkg::A_DEPTH; k++) begin
      a_vec[k*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH] = random_value();
    end
    a_cur = a_vec;
    a_valid = 1'b1;
    @(negedge clk);
    a_valid = 1'b0;
  endtask

  // all words sent and answered
  task automatic wait_idle();
    while (wh_q.size() != 0 || exp_coef_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
  endtask

  // sender with input credits
  initial begin
    wh_valid = 1'b0;
    wh_data = '0;
    in_credits = gat_pkg::IN_CREDITS;
    forever begin
      @(negedge clk);
      wh_valid = 1'b0;
      if (rst_n) begin
        if (wh_credit) begin
          in_credits++;
          credits_seen++;
        end
        if (in_credits > gat_pkg::IN_CREDITS) begin
          report_failure("input credit returned while none was outstanding");
        end else if (gap_left > 0) begin
          gap_left--;
        end else if (wh_q.size() != 0 && in_credits > 0) begin
          wh_data = wh_q.pop_front();
          wh_valid = 1'b1;
          in_credits--;
          words_sent++;
          first_sent = 1'b1;
          gap_left = int'($urandom_range(gap_max));
        end
      end
    end
  end

  // receiver that holds coefficients and returns credits late
  initial begin
    coef_credit = 1'b0;
    forever begin
      @(negedge clk);
      coef_credit = 1'b0;
      if (rst_n) begin
        if (coef_valid) begin
          held++;
        end
        if (held > gat_pkg::OUT_CREDITS) begin
          report_failure("receiver holds more coefficients than its buffer size");
        end else if (stall_left > 0) begin
          stall_left--;
        end else if (stall_enable && stall_phases < MAX_STALLS && $urandom_range(99) < 3) begin
          stall_left = int'($urandom_range(200, 20));
          stall_phases++;
        end else if (held > 0 && $urandom_range(3) == 0) begin
          coef_credit = 1'b1;
          held--;
        end
      end
    end
  end

  // check each coefficient against the queued reference
  always @(negedge clk) begin
    if (rst_n && coef_valid) begin
      if (exp_coef_q.size() == 0) begin
        report_failure("coefficient arrived while none was expected");
      end else begin
        check_coef(exp_coef_q.pop_front(), coef);
        check_last(exp_last_q.pop_front(), coef_last);
      end
    end
  end

  // nothing may come out before the first word
  always @(negedge clk) begin
    if (rst_n && !first_sent) begin
      check_idle("wh_credit_o", wh_credit);
      check_idle("coef_valid_o", coef_valid);
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    void'($urandom(60829));
    rst_n = 1'b0;
    a_valid = 1'b0;
    a_vec = '0;
    gap_max = 3;
    stall_enable = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (8) @(negedge clk);
    load_weights();

    // single group long enough to hit clamped totals
    add_group(12);
    wait_idle();

    // ten groups with no gaps
    gap_max = 0;
    repeat (10) add_group(1 + int'($urandom_range(11)));
    wait_idle();

    // long credit stalls at the output
    gap_max = 3;
    stall_enable = 1'b1;
    repeat (10) add_group(1 + int'($urandom_range(11)));
    wait_idle();
    stall_enable = 1'b0;

    // new weights between idle groups
    repeat (3) begin
      load_weights();
      add_group(1 + int'($urandom_range(11)));
      wait_idle();
    end

    repeat (20) @(negedge clk);
    if (exp_coef_q.size() != 0) begin
      report_failure("expected coefficients were never received");
    end else if (credits_seen != words_sent) begin
      report_failure($sformatf("%0d input credits returned for %0d words sent",
                               credits_seen, words_sent));
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// ==== project.f ====
design/gat_pkg.sv
design/wh_admit.sv
design/dmvm_mult.sv
design/dmvm_reduce.sv
design/coef_fifo.sv
design/gat_coef_top.sv
sim/tb_gat_coef.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_gat_coef -Mdir obj_dir -o tb_gat_coef -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_gat_coef > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^No errors$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1
